/* design/addsub_core.sv */
module addsub_core (
   input  logic              i_ce_clk,
   input  logic              i_rst_n,
   input  addsub_pkg::beat_t i_a,
   input  logic              i_a_valid,
   output logic              o_a_ready,
   input  addsub_pkg::beat_t i_b,
   input  logic              i_b_valid,
   output logic              o_b_ready,
   output addsub_pkg::beat_t o_sum,
   output logic              o_sum_valid,
   input  logic              i_sum_ready,
   output addsub_pkg::beat_t o_diff,
   output logic              o_diff_valid,
   input  logic              i_diff_ready
);

   addsub_pkg::sample_t [1:0] a_s;
   addsub_pkg::sample_t [1:0] b_s;
   addsub_pkg::sample_t [1:0] sum_s;
   addsub_pkg::sample_t [1:0] diff_s;

   logic out_free;
   logic fire;

   ////////////////////////////////////////////////////////////
   // Join
   ////////////////////////////////////////////////////////////
   // Both result registers must be free before a pair is taken
   assign out_free = (!o_sum_valid || i_sum_ready) && (!o_diff_valid || i_diff_ready);
   assign fire     = i_a_valid && i_b_valid && out_free;

   assign o_a_ready = i_b_valid && out_free;
   assign o_b_ready = i_a_valid && out_free;

   ////////////////////////////////////////////////////////////
   // Lane arithmetic, wraps modulo 2^16
   ////////////////////////////////////////////////////////////
   assign a_s = i_a.data;
   assign b_s = i_b.data;

   always_comb begin
      for (int l = 0; l < 2; l++) begin
         sum_s[l].i  = a_s[l].i + b_s[l].i;
         sum_s[l].q  = a_s[l].q + b_s[l].q;
         diff_s[l].i = a_s[l].i - b_s[l].i;
         diff_s[l].q = a_s[l].q - b_s[l].q;
      end
   end

   always_ff @(posedge i_ce_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         o_sum_valid  <= 1'b0;
         o_diff_valid <= 1'b0;
      end else if (fire) begin
         o_sum_valid  <= 1'b1;
         o_diff_valid <= 1'b1;
      end else begin
         // Each side drains on its own
         if (i_sum_ready) begin
            o_sum_valid <= 1'b0;
         end
         if (i_diff_ready) begin
            o_diff_valid <= 1'b0;
         end
      end
   end

   always_ff @(posedge i_ce_clk) begin
      if (fire) begin
         o_sum.data  <= sum_s;
         o_sum.last  <= i_a.last;
         o_diff.data <= diff_s;
         o_diff.last <= i_a.last;
      end
   end

endmodule

/* design/addsub_pkg.sv */
package addsub_pkg;

   ////////////////////////////////////////////////////////////
   // Packet header, one 64-bit word
   ////////////////////////////////////////////////////////////
   typedef struct packed {
      logic [3:0]  pkt_type;
      logic [11:0] seq;
      // Byte count including the header beat
      logic [15:0] len;
      logic [15:0] src_sid;
      logic [15:0] dst_sid;
   } hdr_t;

   // One complex sample
   typedef struct packed {
      logic [15:0] i;
      logic [15:0] q;
   } sample_t;

   // Stream beat, lane 1 in data[63:32], lane 0 in data[31:0]
   typedef struct packed {
      logic [63:0] data;
      logic        last;
   } beat_t;

   ////////////////////////////////////////////////////////////
   // Settings bus
   ////////////////////////////////////////////////////////////
   typedef struct packed {
      logic        stb;
      logic [7:0]  addr;
      logic [31:0] data;
   } set_bus_t;

   // Destination registers
   localparam logic [7:0] SET_DST0 = 8'd0;
   localparam logic [7:0] SET_DST1 = 8'd1;

   // Output port numbers, low nibble of src_sid
   localparam logic [3:0] PORT_SUM  = 4'd0;
   localparam logic [3:0] PORT_DIFF = 4'd1;

endpackage

/* design/hdr_route.sv */
module hdr_route #(
   parameter int HDR_DEPTH_LOG2 = 2
) (
   input  logic                 i_ce_clk,
   input  logic                 i_rst_n,
   input  addsub_pkg::set_bus_t i_set,
   input  addsub_pkg::hdr_t     i_hdr,
   input  logic                 i_hdr_valid,
   output logic                 o_hdr_ready,
   output addsub_pkg::hdr_t     o_sum_hdr,
   output logic                 o_sum_hdr_valid,
   input  logic                 i_sum_take,
   output addsub_pkg::hdr_t     o_diff_hdr,
   output logic                 o_diff_hdr_valid,
   input  logic                 i_diff_take
);

   localparam int DEPTH = 2 ** HDR_DEPTH_LOG2;

   addsub_pkg::hdr_t mem [DEPTH];

   logic [HDR_DEPTH_LOG2:0]       wr_ptr;
   logic [1:0][HDR_DEPTH_LOG2:0]  rd_ptr;
   logic [1:0][HDR_DEPTH_LOG2:0]  fill;
   logic [1:0][15:0]              dst;
   logic [1:0]                    hdr_vld;
   logic [1:0]                    take;
   logic                          push;

   function automatic addsub_pkg::hdr_t rewrite(input addsub_pkg::hdr_t h,
                                                input logic [15:0] dst_sid,
                                                input logic [3:0] port);
      addsub_pkg::hdr_t r;
      r         = h;
      r.src_sid = {h.dst_sid[15:4], port};
      r.dst_sid = dst_sid;
      return r;
   endfunction

   ////////////////////////////////////////////////////////////
   // Destination settings
   ////////////////////////////////////////////////////////////
   always_ff @(posedge i_ce_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         dst <= '0;
      end else if (i_set.stb) begin
         if (i_set.addr == addsub_pkg::SET_DST0) begin
            dst[0] <= i_set.data[15:0];
         end
         if (i_set.addr == addsub_pkg::SET_DST1) begin
            dst[1] <= i_set.data[15:0];
         end
      end
   end

   ////////////////////////////////////////////////////////////
   // Header queue, one read pointer per port
   ////////////////////////////////////////////////////////////
   assign fill[0] = wr_ptr - rd_ptr[0];
   assign fill[1] = wr_ptr - rd_ptr[1];

   // Fill tops out at DEPTH, so the MSB alone marks full
   assign o_hdr_ready = !fill[0][HDR_DEPTH_LOG2] && !fill[1][HDR_DEPTH_LOG2];
   assign push        = i_hdr_valid && o_hdr_ready;

   assign hdr_vld = {fill[1] != '0, fill[0] != '0};
   assign take    = {i_diff_take, i_sum_take} & hdr_vld;

   always_ff @(posedge i_ce_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
      end else begin
         if (push) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         for (int p = 0; p < 2; p++) begin
            if (take[p]) begin
               rd_ptr[p] <= rd_ptr[p] + 1'b1;
            end
         end
      end
   end

   always_ff @(posedge i_ce_clk) begin
      if (push) begin
         mem[wr_ptr[HDR_DEPTH_LOG2-1:0]] <= i_hdr;
      end
   end

   assign o_sum_hdr  = rewrite(mem[rd_ptr[0][HDR_DEPTH_LOG2-1:0]], dst[0],
                               addsub_pkg::PORT_SUM);
   assign o_diff_hdr = rewrite(mem[rd_ptr[1][HDR_DEPTH_LOG2-1:0]], dst[1],
                               addsub_pkg::PORT_DIFF);

   assign o_sum_hdr_valid  = hdr_vld[0];
   assign o_diff_hdr_valid = hdr_vld[1];

endmodule

/* design/noc_block_addsub.sv */
module noc_block_addsub #(
   parameter int MTU_LOG2       = 6,
   parameter int HDR_DEPTH_LOG2 = 2
) (
   input  logic                 i_ce_clk,
   input  logic                 i_rst_n,
   input  addsub_pkg::beat_t    i_in0,
   input  logic                 i_in0_valid,
   output logic                 o_in0_ready,
   input  addsub_pkg::beat_t    i_in1,
   input  logic                 i_in1_valid,
   output logic                 o_in1_ready,
   output addsub_pkg::beat_t    o_sum,
   output logic                 o_sum_valid,
   input  logic                 i_sum_ready,
   output addsub_pkg::beat_t    o_diff,
   output logic                 o_diff_valid,
   input  logic                 i_diff_ready,
   input  addsub_pkg::set_bus_t i_set
);

   addsub_pkg::beat_t pay0, pay1, sum_beat, diff_beat;
   logic              pay0_valid, pay0_ready, pay1_valid, pay1_ready;
   logic              sum_valid, sum_ready, diff_valid, diff_ready;

   addsub_pkg::hdr_t  in_hdr, sum_hdr, diff_hdr;
   logic              in_hdr_valid, in_hdr_ready;
   logic              sum_hdr_valid, sum_hdr_take, diff_hdr_valid, diff_hdr_take;

   ////////////////////////////////////////////////////////////
   // Input deframers, only stream 0 keeps its header
   ////////////////////////////////////////////////////////////
   stream_deframer u_deframer0 (
      .i_ce_clk(i_ce_clk), .i_rst_n(i_rst_n),
      .i_beat(i_in0), .i_valid(i_in0_valid), .o_ready(o_in0_ready),
      .o_hdr(in_hdr), .o_hdr_valid(in_hdr_valid), .i_hdr_ready(in_hdr_ready),
      .o_beat(pay0), .o_valid(pay0_valid), .i_ready(pay0_ready)
   );

   stream_deframer u_deframer1 (
      .i_ce_clk(i_ce_clk), .i_rst_n(i_rst_n),
      .i_beat(i_in1), .i_valid(i_in1_valid), .o_ready(o_in1_ready),
      .o_hdr(), .o_hdr_valid(), .i_hdr_ready(1'b1),
      .o_beat(pay1), .o_valid(pay1_valid), .i_ready(pay1_ready)
   );

   addsub_core u_core (
      .i_ce_clk(i_ce_clk), .i_rst_n(i_rst_n),
      .i_a(pay0), .i_a_valid(pay0_valid), .o_a_ready(pay0_ready),
      .i_b(pay1), .i_b_valid(pay1_valid), .o_b_ready(pay1_ready),
      .o_sum(sum_beat), .o_sum_valid(sum_valid), .i_sum_ready(sum_ready),
      .o_diff(diff_beat), .o_diff_valid(diff_valid), .i_diff_ready(diff_ready)
   );

   hdr_route #(.HDR_DEPTH_LOG2(HDR_DEPTH_LOG2)) u_hdr_route (
      .i_ce_clk(i_ce_clk), .i_rst_n(i_rst_n), .i_set(i_set),
      .i_hdr(in_hdr), .i_hdr_valid(in_hdr_valid), .o_hdr_ready(in_hdr_ready),
      .o_sum_hdr(sum_hdr), .o_sum_hdr_valid(sum_hdr_valid), .i_sum_take(sum_hdr_take),
      .o_diff_hdr(diff_hdr), .o_diff_hdr_valid(diff_hdr_valid), .i_diff_take(diff_hdr_take)
   );

   ////////////////////////////////////////////////////////////
   // Output framers
   ////////////////////////////////////////////////////////////
   stream_framer #(.MTU_LOG2(MTU_LOG2)) u_framer_sum (
      .i_ce_clk(i_ce_clk), .i_rst_n(i_rst_n),
      .i_beat(sum_beat), .i_valid(sum_valid), .o_ready(sum_ready),
      .i_hdr(sum_hdr), .i_hdr_valid(sum_hdr_valid), .o_hdr_take(sum_hdr_take),
      .o_beat(o_sum), .o_valid(o_sum_valid), .i_ready(i_sum_ready)
   );

   stream_framer #(.MTU_LOG2(MTU_LOG2)) u_framer_diff (
      .i_ce_clk(i_ce_clk), .i_rst_n(i_rst_n),
      .i_beat(diff_beat), .i_valid(diff_valid), .o_ready(diff_ready),
      .i_hdr(diff_hdr), .i_hdr_valid(diff_hdr_valid), .o_hdr_take(diff_hdr_take),
      .o_beat(o_diff), .o_valid(o_diff_valid), .i_ready(i_diff_ready)
   );

endmodule

/* design/stream_deframer.sv */
module stream_deframer (
   input  logic              i_ce_clk,
   input  logic              i_rst_n,
   input  addsub_pkg::beat_t i_beat,
   input  logic              i_valid,
   output logic              o_ready,
   output addsub_pkg::hdr_t  o_hdr,
   output logic              o_hdr_valid,
   input  logic              i_hdr_ready,
   output addsub_pkg::beat_t o_beat,
   output logic              o_valid,
   input  logic              i_ready
);

   logic in_hdr;
   logic out_free;
   logic take;
   logic take_payload;

   // Output register can load when empty or draining
   assign out_free     = !o_valid || i_ready;
   assign o_ready      = in_hdr ? i_hdr_ready : out_free;
   assign take         = i_valid && o_ready;
   assign take_payload = take && !in_hdr;

   // Header goes straight to the header consumer
   assign o_hdr       = addsub_pkg::hdr_t'(i_beat.data);
   assign o_hdr_valid = take && in_hdr;

   always_ff @(posedge i_ce_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         in_hdr  <= 1'b1;
         o_valid <= 1'b0;
      end else begin
         // Next beat is a header after any last beat
         if (take) begin
            in_hdr <= i_beat.last;
         end
         if (out_free) begin
            o_valid <= take_payload;
         end
      end
   end

   always_ff @(posedge i_ce_clk) begin
      if (take_payload) begin
         o_beat <= i_beat;
      end
   end

endmodule

/* design/stream_framer.sv */
module stream_framer #(
   parameter int MTU_LOG2 = 6
) (
   input  logic              i_ce_clk,
   input  logic              i_rst_n,
   input  addsub_pkg::beat_t i_beat,
   input  logic              i_valid,
   output logic              o_ready,
   input  addsub_pkg::hdr_t  i_hdr,
   input  logic              i_hdr_valid,
   output logic              o_hdr_take,
   output addsub_pkg::beat_t o_beat,
   output logic              o_valid,
   input  logic              i_ready
);

   typedef enum logic [1:0] {
      S_FILL,
      S_HDR,
      S_DATA
   } state_t;

   logic [63:0] pbuf [2 ** MTU_LOG2];

   state_t              state;
   logic [MTU_LOG2:0]   cnt;
   logic [MTU_LOG2-1:0] rd;
   logic                store;
   logic                last_beat;
   logic [15:0]         len_bytes;
   addsub_pkg::hdr_t    hdr_out;

   ////////////////////////////////////////////////////////////
   // Fill side
   ////////////////////////////////////////////////////////////
   assign o_ready = (state == S_FILL);

   // Beats past the MTU are accepted and dropped
   assign store = i_valid && o_ready && !cnt[MTU_LOG2];

   always_ff @(posedge i_ce_clk) begin
      if (store) begin
         pbuf[cnt[MTU_LOG2-1:0]] <= i_beat.data;
      end
   end

   ////////////////////////////////////////////////////////////
   // Send side
   ////////////////////////////////////////////////////////////
   assign len_bytes = (16'(cnt) + 16'd1) << 3;
   assign last_beat = ({1'b0, rd} + 1'b1) == cnt;

   always_comb begin
      hdr_out     = i_hdr;
      hdr_out.len = len_bytes;
   end

   always_comb begin
      o_beat.data = pbuf[rd];
      o_beat.last = last_beat;
      o_valid     = (state == S_DATA);
      if (state == S_HDR) begin
         o_beat.data = hdr_out;
         o_beat.last = 1'b0;
         o_valid     = i_hdr_valid;
      end
   end

   assign o_hdr_take = (state == S_HDR) && i_hdr_valid && i_ready;

   always_ff @(posedge i_ce_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         state <= S_FILL;
         cnt   <= '0;
         rd    <= '0;
      end else begin
         case (state)
            S_FILL: begin
               if (store) begin
                  cnt <= cnt + 1'b1;
               end
               if (i_valid && i_beat.last) begin
                  state <= S_HDR;
               end
            end
            S_HDR: begin
               rd <= '0;
               if (o_hdr_take) begin
                  state <= S_DATA;
               end
            end
            default: begin
               if (i_ready) begin
                  rd <= rd + 1'b1;
                  if (last_beat) begin
                     cnt   <= '0;
                     state <= S_FILL;
                  end
               end
            end
         endcase
      end
   end

endmodule

/* verif/tb_addsub.sv */
module tb_addsub;
   timeunit 1ns;
   timeprecision 1ps;

   localparam int MTU_LOG2       = 6;
   localparam int HDR_DEPTH_LOG2 = 2;
   localparam int NUM_PKTS       = 30;

   logic clk;
   logic rst_n;

   addsub_pkg::beat_t    in0, in1, sum_beat, diff_beat;
   logic                 in0_valid, in0_ready, in1_valid, in1_ready;
   logic                 sum_valid, sum_ready, diff_valid, diff_ready;
   addsub_pkg::set_bus_t set_bus;

   addsub_pkg::beat_t q0 [$];
   addsub_pkg::beat_t q1 [$];
   addsub_pkg::beat_t exp_beats [2][$];
   addsub_pkg::hdr_t  exp_hdrs [2][$];

   int          lens [NUM_PKTS];
   logic [31:0] lfsr = 32'hccaa_9ebf;
   logic        first_done;
   int          limit_cycles = 0;
   int          value_errors = 0;
   int          protocol_errors = 0;
   int          timeouts = 0;
   logic        at_hdr [2] = '{1'b1, 1'b1};
   int          pkt_cnt [2] = '{0, 0};
   int          beat_cnt [2] = '{0, 0};
   string       port_name [2] = '{"sum", "diff"};

   tb_clock u_clock (.o_clk(clk), .o_rst_n(rst_n));

   noc_block_addsub #(.MTU_LOG2(MTU_LOG2), .HDR_DEPTH_LOG2(HDR_DEPTH_LOG2)) dut (
      .i_ce_clk(clk), .i_rst_n(rst_n),
      .i_in0(in0), .i_in0_valid(in0_valid), .o_in0_ready(in0_ready),
      .i_in1(in1), .i_in1_valid(in1_valid), .o_in1_ready(in1_ready),
      .o_sum(sum_beat), .o_sum_valid(sum_valid), .i_sum_ready(sum_ready),
      .o_diff(diff_beat), .o_diff_valid(diff_valid), .i_diff_ready(diff_ready),
      .i_set(set_bus)
   );

   ////////////////////////////////////////////////////////////
   // Fibonacci LFSR with taps x^32 + x^22 + x^2 + x + 1
   ////////////////////////////////////////////////////////////
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   function automatic logic [31:0] take_bits(input int n);
      logic [31:0] v;
      v = '0;
      for (int k = 0; k < n; k++) begin
         lfsr = lfsr_next(lfsr);
         v    = {v[30:0], lfsr[0]};
      end
      return v;
   endfunction

   // Corner values make the sums and differences wrap
   function automatic logic [15:0] rand_comp();
      case (take_bits(3))
         0: return 16'h7fff;
         1: return 16'h8000;
         2: return 16'hffff;
         default: return 16'(take_bits(16));
      endcase
   endfunction

   function automatic logic [63:0] rand_data();
      logic [63:0] d;
      for (int c = 0; c < 4; c++) begin
         d[16*c +: 16] = rand_comp();
      end
      return d;
   endfunction

   function automatic addsub_pkg::hdr_t make_hdr();
      addsub_pkg::hdr_t h;
      h.pkt_type = 4'(take_bits(4));
      h.seq      = 12'(take_bits(12));
      h.len      = 16'(take_bits(16));
      h.src_sid  = 16'(take_bits(16));
      h.dst_sid  = 16'(take_bits(16));
      return h;
   endfunction

   ////////////////////////////////////////////////////////////
   // Reference model
   ////////////////////////////////////////////////////////////
   function automatic addsub_pkg::beat_t ref_beat(input addsub_pkg::beat_t a,
                                                  input addsub_pkg::beat_t b,
                                                  input logic sub);
      addsub_pkg::beat_t r;
      logic [15:0]       x;
      logic [15:0]       y;
      r.last = a.last;
      for (int c = 0; c < 4; c++) begin
         x = a.data[16*c +: 16];
         y = b.data[16*c +: 16];
         r.data[16*c +: 16] = sub ? x - y : x + y;
      end
      return r;
   endfunction

   function automatic addsub_pkg::hdr_t ref_hdr(input addsub_pkg::hdr_t h,
                                                input logic [15:0] dst,
                                                input logic [3:0] port,
                                                input int beats);
      addsub_pkg::hdr_t r;
      r         = h;
      r.len     = 16'(8 * (beats + 1));
      r.src_sid = {h.dst_sid[15:4], port};
      r.dst_sid = dst;
      return r;
   endfunction

   task automatic check_beat(input string name, input addsub_pkg::beat_t exp,
                             input addsub_pkg::beat_t act);
      if (act !== exp) begin
         value_errors++;
         $display("Fail %s expected %h actual %h", name, exp, act);
      end
   endtask

   task automatic check_hdr(input string name, input addsub_pkg::hdr_t exp,
                            input addsub_pkg::hdr_t act);
      if (act !== exp) begin
         value_errors++;
         $display("Fail %s expected %h actual %h", name, exp, act);
      end
   endtask

   task automatic finish_run();
      $display("Errors: value %0d, protocol %0d, timeout %0d",
               value_errors, protocol_errors, timeouts);
      if (value_errors + protocol_errors + timeouts == 0) begin
         $display("Result: PASSED");
      end else begin
         $display("Result: FAILED");
      end
      $finish;
   endtask

   ////////////////////////////////////////////////////////////
   // Stimulus
   ////////////////////////////////////////////////////////////
   task automatic write_setting(input logic [7:0] addr, input logic [31:0] data);
      @(posedge clk);
      set_bus <= '{stb: 1'b1, addr: addr, data: data};
      @(posedge clk);
      set_bus.stb <= 1'b0;
   endtask

   task automatic drive_inputs();
      logic hold0;
      logic hold1;
      hold0 = in0_valid && !in0_ready;
      hold1 = in1_valid && !in1_ready;
      if (in0_valid && in0_ready) begin
         if (in0.last) begin
            first_done <= 1'b1;
         end
         void'(q0.pop_front());
      end
      if (in1_valid && in1_ready) begin
         void'(q1.pop_front());
      end
      if (!hold0) begin
         in0_valid <= (q0.size() != 0) && (take_bits(2) != 0);
         if (q0.size() != 0) begin
            in0 <= q0[0];
         end
      end
      if (!hold1) begin
         in1_valid <= (q1.size() != 0) && (take_bits(2) != 0);
         if (q1.size() != 0) begin
            in1 <= q1[0];
         end
      end
      sum_ready  <= take_bits(2) != 0;
      diff_ready <= take_bits(2) != 0;
   endtask

   task automatic run_phase(input int first, input int count, input logic write_dst,
                            input logic [15:0] d0, input logic [15:0] d1);
      addsub_pkg::hdr_t  h0;
      addsub_pkg::beat_t a;
      addsub_pkg::beat_t b;
      logic              idle;
      if (write_dst) begin
         write_setting(addsub_pkg::SET_DST0, {16'hffff, d0});
         write_setting(addsub_pkg::SET_DST1, {16'hffff, d1});
         // Unused address leaves both destinations alone
         write_setting(8'd7, 32'hdead_5555);
      end
      for (int p = first; p < first + count; p++) begin
         h0 = make_hdr();
         q0.push_back('{data: h0, last: 1'b0});
         q1.push_back('{data: make_hdr(), last: 1'b0});
         exp_hdrs[0].push_back(ref_hdr(h0, d0, addsub_pkg::PORT_SUM, lens[p]));
         exp_hdrs[1].push_back(ref_hdr(h0, d1, addsub_pkg::PORT_DIFF, lens[p]));
         for (int k = 0; k < lens[p]; k++) begin
            a.data = rand_data();
            a.last = (k == lens[p] - 1);
            b.data = rand_data();
            b.last = a.last;
            q0.push_back(a);
            q1.push_back(b);
            exp_beats[0].push_back(ref_beat(a, b, 1'b0));
            exp_beats[1].push_back(ref_beat(a, b, 1'b1));
         end
      end
      idle = 1'b0;
      while (!idle) begin
         @(posedge clk);
         drive_inputs();
         @(negedge clk);
         idle = q0.size() == 0 && q1.size() == 0 && !in0_valid && !in1_valid &&
                exp_hdrs[0].size() == 0 && exp_hdrs[1].size() == 0 &&
                exp_beats[0].size() == 0 && exp_beats[1].size() == 0;
      end
   endtask

   initial begin
      int total;
      in0        = '0;
      in1        = '0;
      in0_valid  = 1'b0;
      in1_valid  = 1'b0;
      sum_ready  = 1'b0;
      diff_ready = 1'b0;
      set_bus    = '0;
      first_done = 1'b0;
      total      = 0;
      for (int p = 0; p < NUM_PKTS; p++) begin
         lens[p] = 1 + int'(take_bits(MTU_LOG2));
         if (p == 0) begin
            lens[p] = 1;
         end else if (p == 17) begin
            lens[p] = 2 ** MTU_LOG2;
         end
         total += 2 * (lens[p] + 1);
      end
      limit_cycles = total * 40 + 2000;
      @(posedge rst_n);
      // First phase runs on the reset destinations
      run_phase(0, 10, 1'b0, 16'h0000, 16'h0000);
      run_phase(10, 10, 1'b1, 16'h1a2b, 16'h3c4d);
      run_phase(20, 10, 1'b1, 16'hbe0f, 16'hf00d);
      repeat (4) @(posedge clk);
      finish_run();
   end

   ////////////////////////////////////////////////////////////
   // Output comparison
   ////////////////////////////////////////////////////////////
   always @(posedge clk) begin : compare_outputs
      addsub_pkg::beat_t act [2];
      addsub_pkg::beat_t exp_b;
      logic [1:0]        fire;
      act[0] = sum_beat;
      act[1] = diff_beat;
      fire   = {diff_valid && diff_ready, sum_valid && sum_ready};
      if (rst_n && !first_done && (sum_valid !== 1'b0 || diff_valid !== 1'b0)) begin
         protocol_errors++;
         $display("An output became valid before the first input packet completed");
      end
      for (int p = 0; p < 2; p++) begin
         if (rst_n && fire[p]) begin
            if (at_hdr[p] && exp_hdrs[p].size() == 0) begin
               protocol_errors++;
               $display("The %s output sent a header that was not expected", port_name[p]);
            end else if (at_hdr[p]) begin
               check_hdr($sformatf("%s header pkt %0d", port_name[p], pkt_cnt[p]),
                         exp_hdrs[p].pop_front(), addsub_pkg::hdr_t'(act[p].data));
               if (act[p].last) begin
                  protocol_errors++;
                  $display("The %s header beat carried the last flag", port_name[p]);
               end
               at_hdr[p]   = 1'b0;
               beat_cnt[p] = 0;
            end else if (exp_beats[p].size() == 0) begin
               protocol_errors++;
               $display("The %s output sent a payload beat that was not expected", port_name[p]);
            end else begin
               exp_b = exp_beats[p].pop_front();
               check_beat($sformatf("%s payload pkt %0d beat %0d", port_name[p], pkt_cnt[p],
                                    beat_cnt[p]), exp_b, act[p]);
               beat_cnt[p]++;
               if (exp_b.last) begin
                  at_hdr[p] = 1'b1;
                  pkt_cnt[p]++;
               end
            end
         end
      end
   end

   initial begin : watchdog
      wait (limit_cycles != 0);
      repeat (limit_cycles) @(posedge clk);
      timeouts++;
      $display("Timeout after %0d cycles, the outputs did not deliver every packet",
               limit_cycles);
      finish_run();
   end

endmodule

/* verif/tb_clock.sv */
module tb_clock (
   output logic o_clk,
   output logic o_rst_n
);
   timeunit 1ns;
   timeprecision 1ps;

   // 40 ns period
   initial begin
      o_clk = 1'b0;
      forever #20 o_clk = ~o_clk;
   end

   initial begin
      o_rst_n = 1'b0;
      repeat (4) @(posedge o_clk);
      o_rst_n <= 1'b1;
   end

endmodule

/* verilog.f */
design/addsub_pkg.sv
design/stream_deframer.sv
design/addsub_core.sv
design/hdr_route.sv
design/stream_framer.sv
design/noc_block_addsub.sv
verif/tb_clock.sv
verif/tb_addsub.sv
